/* logic/bus_decoder.sv */
/*
 * bus decoder
 * maps the master address to a device and holds the choice
 * until the response of that transaction completes
 */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
	parameter int SRAM_DEPTH = 256
) (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire [bus_pkg::ADDR_W-1:0] ar_addr_i,
	input  wire                       ar_valid_i,
	input  wire [bus_pkg::ADDR_W-1:0] aw_addr_i,
	input  wire                       aw_valid_i,
	input  wire                       txn_done_i,
	output bus_pkg::bus_dev_e         dev_sel_o,
	output logic                      rd_sel_o
);

	typedef enum logic [1:0] {DEC_IDLE, DEC_READ, DEC_WRITE} dec_state_e;

	localparam logic [bus_pkg::ADDR_W-1:0] SRAM_BYTES = SRAM_DEPTH * 4;

	dec_state_e        state;
	bus_pkg::bus_dev_e lock_dev;
	bus_pkg::bus_dev_e rd_dev;
	bus_pkg::bus_dev_e wr_dev;

	function automatic logic in_sram(input logic [bus_pkg::ADDR_W-1:0] addr);
		logic [bus_pkg::ADDR_W-1:0] offs;
		offs = addr - bus_pkg::SRAM_BASE; // wraps below base, so one compare
		return offs < SRAM_BYTES;
	endfunction

	// read map: sram and the two mtime words
	always_comb begin
		if (in_sram(ar_addr_i))
			rd_dev = bus_pkg::DEV_SRAM;
		else if (ar_addr_i == bus_pkg::CLINT_MTIME_LO || ar_addr_i == bus_pkg::CLINT_MTIME_HI)
			rd_dev = bus_pkg::DEV_CLINT;
		else
			rd_dev = bus_pkg::DEV_ERR;
	end

	// write map: sram and the uart tx register
	always_comb begin
		if (in_sram(aw_addr_i))
			wr_dev = bus_pkg::DEV_SRAM;
		else if (aw_addr_i == bus_pkg::UART_TX_ADDR)
			wr_dev = bus_pkg::DEV_UART;
		else
			wr_dev = bus_pkg::DEV_ERR;
	end

	always_comb begin
		if (state != DEC_IDLE) begin
			dev_sel_o = lock_dev;
			rd_sel_o  = (state == DEC_READ);
		end else if (ar_valid_i) begin // reads win
			dev_sel_o = rd_dev;
			rd_sel_o  = 1'b1;
		end else begin
			dev_sel_o = wr_dev;
			rd_sel_o  = 1'b0;
		end
	end

	// an idle target accepts a request in the cycle it shows up
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state    <= DEC_IDLE;
			lock_dev <= bus_pkg::DEV_ERR;
		end else begin
			case (state)
				DEC_IDLE: begin
					if (ar_valid_i) begin
						state    <= DEC_READ;
						lock_dev <= rd_dev;
					end else if (aw_valid_i) begin
						state    <= DEC_WRITE;
						lock_dev <= wr_dev;
					end
				end
				default: if (txn_done_i) state <= DEC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/bus_pkg.sv */
/*
 * bus package
 * shared widths, address map and enums for the memory-mapped fabric
 */
`default_nettype none

package bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// address map
	localparam logic [ADDR_W-1:0] SRAM_BASE      = 32'h8000_0000;
	localparam logic [ADDR_W-1:0] UART_TX_ADDR   = 32'ha000_03f8;
	localparam logic [ADDR_W-1:0] CLINT_MTIME_LO = 32'ha000_0048;
	localparam logic [ADDR_W-1:0] CLINT_MTIME_HI = 32'ha000_004c;

	// target of one transaction
	typedef enum logic [1:0] {
		DEV_SRAM,
		DEV_UART,
		DEV_CLINT,
		DEV_ERR
	} bus_dev_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_DECERR = 2'd3
	} bus_resp_e;

endpackage

`default_nettype wire

/* logic/bus_top.sv */
/*
 * bus fabric top
 * decoder, crossbar and the sram, uart and clint slaves
 */
`timescale 1ns/1ps
`default_nettype none

module bus_top #(
	parameter int SRAM_DEPTH = 256
) (
	input  wire                         clk,
	input  wire                         rst_i,
	input  wire [bus_pkg::ADDR_W-1:0]   m_ar_addr_i,
	input  wire                         m_ar_valid_i,
	output logic                        m_ar_ready_o,
	output logic [bus_pkg::DATA_W-1:0]  m_r_data_o,
	output logic [1:0]                  m_r_resp_o,
	output logic                        m_r_valid_o,
	input  wire                         m_r_ready_i,
	input  wire [bus_pkg::ADDR_W-1:0]   m_aw_addr_i,
	input  wire                         m_aw_valid_i,
	output logic                        m_aw_ready_o,
	input  wire [bus_pkg::DATA_W-1:0]   m_w_data_i,
	input  wire [bus_pkg::DATA_W/8-1:0] m_w_strb_i,
	input  wire                         m_w_valid_i,
	output logic                        m_w_ready_o,
	output logic [1:0]                  m_b_resp_o,
	output logic                        m_b_valid_o,
	input  wire                         m_b_ready_i,
	output logic [7:0]                  uart_tx_data_o,
	output logic                        uart_tx_valid_o
);

	bus_pkg::bus_dev_e            dev_sel;
	logic                         rd_sel, txn_done;
	logic [bus_pkg::ADDR_W-1:0]   sram_ar_addr, sram_aw_addr, clint_ar_addr;
	logic [bus_pkg::DATA_W-1:0]   sram_r_data, sram_w_data, uart_w_data, clint_r_data;
	logic [bus_pkg::DATA_W/8-1:0] sram_w_strb;
	logic [1:0]                   sram_r_resp, sram_b_resp, uart_b_resp, clint_r_resp;
	logic sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
	logic sram_aw_valid, sram_aw_ready, sram_w_valid, sram_w_ready;
	logic sram_b_valid, sram_b_ready;
	logic uart_aw_valid, uart_aw_ready, uart_w_valid, uart_w_ready;
	logic uart_b_valid, uart_b_ready;
	logic clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;

	bus_decoder #(.SRAM_DEPTH(SRAM_DEPTH)) u_dec (
		.clk(clk), .rst_i(rst_i),
		.ar_addr_i(m_ar_addr_i), .ar_valid_i(m_ar_valid_i),
		.aw_addr_i(m_aw_addr_i), .aw_valid_i(m_aw_valid_i),
		.txn_done_i(txn_done), .dev_sel_o(dev_sel), .rd_sel_o(rd_sel)
	);

	bus_xbar u_xbar (
		.clk(clk), .rst_i(rst_i),
		.m_ar_addr_i(m_ar_addr_i), .m_ar_valid_i(m_ar_valid_i), .m_ar_ready_o(m_ar_ready_o),
		.m_r_data_o(m_r_data_o), .m_r_resp_o(m_r_resp_o),
		.m_r_valid_o(m_r_valid_o), .m_r_ready_i(m_r_ready_i),
		.m_aw_addr_i(m_aw_addr_i), .m_aw_valid_i(m_aw_valid_i), .m_aw_ready_o(m_aw_ready_o),
		.m_w_data_i(m_w_data_i), .m_w_strb_i(m_w_strb_i),
		.m_w_valid_i(m_w_valid_i), .m_w_ready_o(m_w_ready_o),
		.m_b_resp_o(m_b_resp_o), .m_b_valid_o(m_b_valid_o), .m_b_ready_i(m_b_ready_i),
		.dev_sel_i(dev_sel), .rd_sel_i(rd_sel), .txn_done_o(txn_done),
		.sram_ar_addr_o(sram_ar_addr), .sram_ar_valid_o(sram_ar_valid),
		.sram_ar_ready_i(sram_ar_ready),
		.sram_r_data_i(sram_r_data), .sram_r_resp_i(sram_r_resp),
		.sram_r_valid_i(sram_r_valid), .sram_r_ready_o(sram_r_ready),
		.sram_aw_addr_o(sram_aw_addr), .sram_aw_valid_o(sram_aw_valid),
		.sram_aw_ready_i(sram_aw_ready),
		.sram_w_data_o(sram_w_data), .sram_w_strb_o(sram_w_strb),
		.sram_w_valid_o(sram_w_valid), .sram_w_ready_i(sram_w_ready),
		.sram_b_resp_i(sram_b_resp), .sram_b_valid_i(sram_b_valid),
		.sram_b_ready_o(sram_b_ready),
		.uart_aw_valid_o(uart_aw_valid), .uart_aw_ready_i(uart_aw_ready),
		.uart_w_data_o(uart_w_data), .uart_w_valid_o(uart_w_valid),
		.uart_w_ready_i(uart_w_ready),
		.uart_b_resp_i(uart_b_resp), .uart_b_valid_i(uart_b_valid),
		.uart_b_ready_o(uart_b_ready),
		.clint_ar_addr_o(clint_ar_addr), .clint_ar_valid_o(clint_ar_valid),
		.clint_ar_ready_i(clint_ar_ready),
		.clint_r_data_i(clint_r_data), .clint_r_resp_i(clint_r_resp),
		.clint_r_valid_i(clint_r_valid), .clint_r_ready_o(clint_r_ready)
	);

	sram_slave #(.SRAM_DEPTH(SRAM_DEPTH)) u_sram (
		.clk(clk), .rst_i(rst_i),
		.ar_addr_i(sram_ar_addr), .ar_valid_i(sram_ar_valid), .ar_ready_o(sram_ar_ready),
		.r_data_o(sram_r_data), .r_resp_o(sram_r_resp),
		.r_valid_o(sram_r_valid), .r_ready_i(sram_r_ready),
		.aw_addr_i(sram_aw_addr), .aw_valid_i(sram_aw_valid), .aw_ready_o(sram_aw_ready),
		.w_data_i(sram_w_data), .w_strb_i(sram_w_strb),
		.w_valid_i(sram_w_valid), .w_ready_o(sram_w_ready),
		.b_resp_o(sram_b_resp), .b_valid_o(sram_b_valid), .b_ready_i(sram_b_ready)
	);

	uart_slave u_uart (
		.clk(clk), .rst_i(rst_i),
		.aw_valid_i(uart_aw_valid), .aw_ready_o(uart_aw_ready),
		.w_data_i(uart_w_data), .w_valid_i(uart_w_valid), .w_ready_o(uart_w_ready),
		.b_resp_o(uart_b_resp), .b_valid_o(uart_b_valid), .b_ready_i(uart_b_ready),
		.tx_data_o(uart_tx_data_o), .tx_valid_o(uart_tx_valid_o)
	);

	clint_slave u_clint (
		.clk(clk), .rst_i(rst_i),
		.ar_addr_i(clint_ar_addr), .ar_valid_i(clint_ar_valid), .ar_ready_o(clint_ar_ready),
		.r_data_o(clint_r_data), .r_resp_o(clint_r_resp),
		.r_valid_o(clint_r_valid), .r_ready_i(clint_r_ready)
	);

endmodule

`default_nettype wire

/* logic/bus_xbar.sv */
/*
 * bus crossbar
 * steers one master to the selected slave and answers
 * unmapped accesses with DECERR from its own responder
 */
`timescale 1ns/1ps
`default_nettype none

module bus_xbar (
	input  wire                         clk,
	input  wire                         rst_i,
	// master side
	input  wire [bus_pkg::ADDR_W-1:0]   m_ar_addr_i,
	input  wire                         m_ar_valid_i,
	output logic                        m_ar_ready_o,
	output logic [bus_pkg::DATA_W-1:0]  m_r_data_o,
	output logic [1:0]                  m_r_resp_o,
	output logic                        m_r_valid_o,
	input  wire                         m_r_ready_i,
	input  wire [bus_pkg::ADDR_W-1:0]   m_aw_addr_i,
	input  wire                         m_aw_valid_i,
	output logic                        m_aw_ready_o,
	input  wire [bus_pkg::DATA_W-1:0]   m_w_data_i,
	input  wire [bus_pkg::DATA_W/8-1:0] m_w_strb_i,
	input  wire                         m_w_valid_i,
	output logic                        m_w_ready_o,
	output logic [1:0]                  m_b_resp_o,
	output logic                        m_b_valid_o,
	input  wire                         m_b_ready_i,
	// decoder
	input  wire bus_pkg::bus_dev_e      dev_sel_i,
	input  wire                         rd_sel_i,
	output logic                        txn_done_o,
	// sram
	output logic [bus_pkg::ADDR_W-1:0]   sram_ar_addr_o,
	output logic                         sram_ar_valid_o,
	input  wire                          sram_ar_ready_i,
	input  wire [bus_pkg::DATA_W-1:0]    sram_r_data_i,
	input  wire [1:0]                    sram_r_resp_i,
	input  wire                          sram_r_valid_i,
	output logic                         sram_r_ready_o,
	output logic [bus_pkg::ADDR_W-1:0]   sram_aw_addr_o,
	output logic                         sram_aw_valid_o,
	input  wire                          sram_aw_ready_i,
	output logic [bus_pkg::DATA_W-1:0]   sram_w_data_o,
	output logic [bus_pkg::DATA_W/8-1:0] sram_w_strb_o,
	output logic                         sram_w_valid_o,
	input  wire                          sram_w_ready_i,
	input  wire [1:0]                    sram_b_resp_i,
	input  wire                          sram_b_valid_i,
	output logic                         sram_b_ready_o,
	// uart, write only
	output logic                         uart_aw_valid_o,
	input  wire                          uart_aw_ready_i,
	output logic [bus_pkg::DATA_W-1:0]   uart_w_data_o,
	output logic                         uart_w_valid_o,
	input  wire                          uart_w_ready_i,
	input  wire [1:0]                    uart_b_resp_i,
	input  wire                          uart_b_valid_i,
	output logic                         uart_b_ready_o,
	// clint, read only
	output logic [bus_pkg::ADDR_W-1:0]   clint_ar_addr_o,
	output logic                         clint_ar_valid_o,
	input  wire                          clint_ar_ready_i,
	input  wire [bus_pkg::DATA_W-1:0]    clint_r_data_i,
	input  wire [1:0]                    clint_r_resp_i,
	input  wire                          clint_r_valid_i,
	output logic                         clint_r_ready_o
);

	logic sel_sram, sel_uart, sel_clint;
	logic err_rd, err_wr;
	logic err_r_pend, err_b_pend;

	assign sel_sram  = (dev_sel_i == bus_pkg::DEV_SRAM);
	assign sel_uart  = (dev_sel_i == bus_pkg::DEV_UART);
	assign sel_clint = (dev_sel_i == bus_pkg::DEV_CLINT);
	assign err_rd    = (dev_sel_i == bus_pkg::DEV_ERR) & rd_sel_i;
	assign err_wr    = (dev_sel_i == bus_pkg::DEV_ERR) & ~rd_sel_i;

	// requests go out only to the selected slave
	assign sram_ar_addr_o   = sel_sram ? m_ar_addr_i : '0;
	assign sram_ar_valid_o  = sel_sram & m_ar_valid_i;
	assign sram_r_ready_o   = sel_sram & m_r_ready_i;
	assign sram_aw_addr_o   = sel_sram ? m_aw_addr_i : '0;
	assign sram_aw_valid_o  = sel_sram & m_aw_valid_i;
	assign sram_w_data_o    = sel_sram ? m_w_data_i : '0;
	assign sram_w_strb_o    = sel_sram ? m_w_strb_i : '0;
	assign sram_w_valid_o   = sel_sram & m_w_valid_i;
	assign sram_b_ready_o   = sel_sram & m_b_ready_i;
	assign uart_aw_valid_o  = sel_uart & m_aw_valid_i;
	assign uart_w_data_o    = sel_uart ? m_w_data_i : '0;
	assign uart_w_valid_o   = sel_uart & m_w_valid_i;
	assign uart_b_ready_o   = sel_uart & m_b_ready_i;
	assign clint_ar_addr_o  = sel_clint ? m_ar_addr_i : '0;
	assign clint_ar_valid_o = sel_clint & m_ar_valid_i;
	assign clint_r_ready_o  = sel_clint & m_r_ready_i;

	always_comb begin
		m_ar_ready_o = 1'b0;
		m_r_data_o   = '0;
		m_r_resp_o   = bus_pkg::RESP_OKAY;
		m_r_valid_o  = 1'b0;
		m_aw_ready_o = 1'b0;
		m_w_ready_o  = 1'b0;
		m_b_resp_o   = bus_pkg::RESP_OKAY;
		m_b_valid_o  = 1'b0;
		case (dev_sel_i)
			bus_pkg::DEV_SRAM: begin
				m_ar_ready_o = sram_ar_ready_i;
				m_r_data_o   = sram_r_data_i;
				m_r_resp_o   = sram_r_resp_i;
				m_r_valid_o  = sram_r_valid_i;
				m_aw_ready_o = sram_aw_ready_i;
				m_w_ready_o  = sram_w_ready_i;
				m_b_resp_o   = sram_b_resp_i;
				m_b_valid_o  = sram_b_valid_i;
			end
			bus_pkg::DEV_UART: begin
				m_aw_ready_o = uart_aw_ready_i;
				m_w_ready_o  = uart_w_ready_i;
				m_b_resp_o   = uart_b_resp_i;
				m_b_valid_o  = uart_b_valid_i;
			end
			bus_pkg::DEV_CLINT: begin
				m_ar_ready_o = clint_ar_ready_i;
				m_r_data_o   = clint_r_data_i;
				m_r_resp_o   = clint_r_resp_i;
				m_r_valid_o  = clint_r_valid_i;
			end
			default: begin // local error responder, data stays zero
				m_ar_ready_o = err_rd & ~err_r_pend;
				m_r_resp_o   = bus_pkg::RESP_DECERR;
				m_r_valid_o  = err_r_pend;
				m_aw_ready_o = err_wr & m_aw_valid_i & m_w_valid_i & ~err_b_pend;
				m_w_ready_o  = err_wr & m_aw_valid_i & m_w_valid_i & ~err_b_pend;
				m_b_resp_o   = bus_pkg::RESP_DECERR;
				m_b_valid_o  = err_b_pend;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			err_r_pend <= 1'b0;
			err_b_pend <= 1'b0;
		end else begin
			if (err_rd & m_ar_valid_i & ~err_r_pend)
				err_r_pend <= 1'b1;
			else if (err_r_pend & m_r_ready_i)
				err_r_pend <= 1'b0;
			if (err_wr & m_aw_valid_i & m_w_valid_i & ~err_b_pend)
				err_b_pend <= 1'b1;
			else if (err_b_pend & m_b_ready_i)
				err_b_pend <= 1'b0;
		end
	end

	// frees the decoder lock
	assign txn_done_o = (m_r_valid_o & m_r_ready_i) | (m_b_valid_o & m_b_ready_i);

endmodule

`default_nettype wire

/* logic/clint_slave.sv */
/*
 * clint timer slave
 * free-running 64-bit mtime, read as low and high words
 */
`timescale 1ns/1ps
`default_nettype none

module clint_slave (
	input  wire                        clk,
	input  wire                        rst_i,
	input  wire [bus_pkg::ADDR_W-1:0]  ar_addr_i,
	input  wire                        ar_valid_i,
	output logic                       ar_ready_o,
	output logic [bus_pkg::DATA_W-1:0] r_data_o,
	output logic [1:0]                 r_resp_o,
	output logic                       r_valid_o,
	input  wire                        r_ready_i
);

	logic [63:0] mtime;
	logic        rd_hs;

	assign ar_ready_o = ~r_valid_o;
	assign rd_hs      = ar_valid_i & ar_ready_o;
	assign r_resp_o   = bus_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rd_hs)
			r_data_o <= ar_addr_i[2] ? mtime[63:32] : mtime[31:0]; // bit 2 picks the word
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mtime     <= '0;
			r_valid_o <= 1'b0;
		end else begin
			mtime <= mtime + 64'd1;
			if (rd_hs)
				r_valid_o <= 1'b1;
			else if (r_ready_i)
				r_valid_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/sram_slave.sv */
/*
 * sram slave
 * word-addressed memory with byte strobes, one-cycle responses
 */
`timescale 1ns/1ps
`default_nettype none

module sram_slave #(
	parameter int SRAM_DEPTH = 256
) (
	input  wire                         clk,
	input  wire                         rst_i,
	input  wire [bus_pkg::ADDR_W-1:0]   ar_addr_i,
	input  wire                         ar_valid_i,
	output logic                        ar_ready_o,
	output logic [bus_pkg::DATA_W-1:0]  r_data_o,
	output logic [1:0]                  r_resp_o,
	output logic                        r_valid_o,
	input  wire                         r_ready_i,
	input  wire [bus_pkg::ADDR_W-1:0]   aw_addr_i,
	input  wire                         aw_valid_i,
	output logic                        aw_ready_o,
	input  wire [bus_pkg::DATA_W-1:0]   w_data_i,
	input  wire [bus_pkg::DATA_W/8-1:0] w_strb_i,
	input  wire                         w_valid_i,
	output logic                        w_ready_o,
	output logic [1:0]                  b_resp_o,
	output logic                        b_valid_o,
	input  wire                         b_ready_i
);

	localparam int IDX_W = $clog2(SRAM_DEPTH);

	logic [bus_pkg::DATA_W-1:0] mem [SRAM_DEPTH];
	logic [IDX_W-1:0]           rd_idx, wr_idx;
	logic                       rd_hs, wr_hs;

	assign rd_idx = ar_addr_i[IDX_W+1:2]; // word index
	assign wr_idx = aw_addr_i[IDX_W+1:2];

	// one request at a time per direction
	assign ar_ready_o = ~r_valid_o;
	assign aw_ready_o = aw_valid_i & w_valid_i & ~b_valid_o;
	assign w_ready_o  = aw_valid_i & w_valid_i & ~b_valid_o;

	assign rd_hs = ar_valid_i & ar_ready_o;
	assign wr_hs = aw_valid_i & w_valid_i & ~b_valid_o;

	assign r_resp_o = bus_pkg::RESP_OKAY;
	assign b_resp_o = bus_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			for (int i = 0; i < bus_pkg::DATA_W / 8; i++) begin
				if (w_strb_i[i])
					mem[wr_idx][8*i +: 8] <= w_data_i[8*i +: 8];
			end
		end
		if (rd_hs)
			r_data_o <= mem[rd_idx]; // held until R handshake
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			r_valid_o <= 1'b0;
			b_valid_o <= 1'b0;
		end else begin
			if (rd_hs)
				r_valid_o <= 1'b1;
			else if (r_ready_i)
				r_valid_o <= 1'b0;
			if (wr_hs)
				b_valid_o <= 1'b1;
			else if (b_ready_i)
				b_valid_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/uart_slave.sv */
/*
 * uart transmit slave
 * each accepted write leaves as a one-cycle byte strobe
 */
`timescale 1ns/1ps
`default_nettype none

module uart_slave (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       aw_valid_i,
	output logic                      aw_ready_o,
	input  wire [bus_pkg::DATA_W-1:0] w_data_i,
	input  wire                       w_valid_i,
	output logic                      w_ready_o,
	output logic [1:0]                b_resp_o,
	output logic                      b_valid_o,
	input  wire                       b_ready_i,
	output logic [7:0]                tx_data_o,
	output logic                      tx_valid_o
);

	logic wr_hs;

	// address is already decoded, only the valids matter here
	assign wr_hs      = aw_valid_i & w_valid_i & ~b_valid_o;
	assign aw_ready_o = wr_hs;
	assign w_ready_o  = wr_hs;
	assign b_resp_o   = bus_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (wr_hs)
			tx_data_o <= w_data_i[7:0]; // low byte only
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			tx_valid_o <= 1'b0;
			b_valid_o  <= 1'b0;
		end else begin
			tx_valid_o <= wr_hs;
			if (wr_hs)
				b_valid_o <= 1'b1;
			else if (b_ready_i)
				b_valid_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
logic/bus_pkg.sv
logic/bus_decoder.sv
logic/bus_xbar.sv
logic/sram_slave.sv
logic/uart_slave.sv
logic/clint_slave.sv
logic/bus_top.sv
verif/tb_bus_top.sv

/* verif/tb_bus_top.sv */
/*
 * testbench for the bus fabric top
 * xorshift stimulus on the master port, checked against a
 * reference memory model and the address map rules
 */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_top;

	localparam int SRAM_DEPTH = 256;
	localparam int CLK_PERIOD = 100;
	localparam int QTR        = CLK_PERIOD / 4;
	localparam int N_RAND     = 64;
	localparam int N_UART     = 8;
	localparam int N_CLINT    = 8;
	localparam int N_BP       = 16;
	// preload, random writes and reads, uart, clint, errors and reread, back-pressure
	localparam int N_TXN = 2 * SRAM_DEPTH + 2 * N_RAND + N_UART + N_CLINT + 5 + 2 * N_BP + 4;
	localparam int CYCLE_LIMIT = 200 * N_TXN;

	logic        clk = 1'b0;
	logic        rst_i;
	logic [31:0] m_ar_addr_i, m_aw_addr_i, m_w_data_i;
	logic        m_ar_valid_i, m_aw_valid_i, m_w_valid_i;
	logic [3:0]  m_w_strb_i;
	logic        m_r_ready_i, m_b_ready_i;
	logic        m_ar_ready_o, m_aw_ready_o, m_w_ready_o;
	logic [31:0] m_r_data_o;
	logic [1:0]  m_r_resp_o, m_b_resp_o;
	logic        m_r_valid_o, m_b_valid_o;
	logic [7:0]  uart_tx_data_o;
	logic        uart_tx_valid_o;

	logic [31:0] ref_mem [SRAM_DEPTH];
	bit          touched [SRAM_DEPTH];
	logic [31:0] rng_state = 32'hd4bc_87eb;
	int          cycle_cnt = 0;
	int          tx_count  = 0;
	logic [7:0]  tx_last;

	always #(CLK_PERIOD / 2) clk = ~clk;

	bus_top #(.SRAM_DEPTH(SRAM_DEPTH)) uut (
		.clk(clk), .rst_i(rst_i),
		.m_ar_addr_i(m_ar_addr_i), .m_ar_valid_i(m_ar_valid_i), .m_ar_ready_o(m_ar_ready_o),
		.m_r_data_o(m_r_data_o), .m_r_resp_o(m_r_resp_o),
		.m_r_valid_o(m_r_valid_o), .m_r_ready_i(m_r_ready_i),
		.m_aw_addr_i(m_aw_addr_i), .m_aw_valid_i(m_aw_valid_i), .m_aw_ready_o(m_aw_ready_o),
		.m_w_data_i(m_w_data_i), .m_w_strb_i(m_w_strb_i),
		.m_w_valid_i(m_w_valid_i), .m_w_ready_o(m_w_ready_o),
		.m_b_resp_o(m_b_resp_o), .m_b_valid_o(m_b_valid_o), .m_b_ready_i(m_b_ready_i),
		.uart_tx_data_o(uart_tx_data_o), .uart_tx_valid_o(uart_tx_valid_o)
	);

	function automatic logic [31:0] xorshift();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// initial sram image, spread over the whole address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b9) ^ 32'hc3a5_5a3c;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
		input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		return ref_mem[(addr - bus_pkg::SRAM_BASE) >> 2];
	endfunction

	task automatic fail_and_stop();
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
			fail_and_stop();
		end
	endtask

	// called on a falling edge, returns on one
	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int hold, output logic [1:0] resp);
		logic hs;
		m_aw_addr_i  = addr;
		m_aw_valid_i = 1'b1;
		m_w_data_i   = data;
		m_w_strb_i   = strb;
		m_w_valid_i  = 1'b1;
		m_b_ready_i  = 1'b0;
		do begin
			#QTR;
			hs = m_aw_ready_o & m_w_ready_o;
			@(negedge clk);
		end while (!hs);
		m_aw_valid_i = 1'b0;
		m_w_valid_i  = 1'b0;
		#QTR;
		check_value("m_b_valid_o", m_b_valid_o, 1'b1); // one cycle after the handshake
		resp = m_b_resp_o;
		repeat (hold) begin
			@(negedge clk);
			#QTR;
			check_value("m_b_valid_o", m_b_valid_o, 1'b1);
			check_value("m_b_resp_o", m_b_resp_o, resp);
		end
		@(negedge clk);
		m_b_ready_i = 1'b1;
		@(negedge clk);
		m_b_ready_i = 1'b0;
	endtask

	task automatic bus_read(input logic [31:0] addr, input int hold,
		output logic [31:0] data, output logic [1:0] resp);
		logic hs;
		m_ar_addr_i  = addr;
		m_ar_valid_i = 1'b1;
		m_r_ready_i  = 1'b0;
		do begin
			#QTR;
			hs = m_ar_ready_o;
			@(negedge clk);
		end while (!hs);
		m_ar_valid_i = 1'b0;
		#QTR;
		check_value("m_r_valid_o", m_r_valid_o, 1'b1);
		data = m_r_data_o;
		resp = m_r_resp_o;
		repeat (hold) begin // response must not move while stalled
			@(negedge clk);
			#QTR;
			check_value("m_r_valid_o", m_r_valid_o, 1'b1);
			check_value("m_r_data_o", m_r_data_o, data);
			check_value("m_r_resp_o", m_r_resp_o, resp);
		end
		@(negedge clk);
		m_r_ready_i = 1'b1;
		@(negedge clk);
		m_r_ready_i = 1'b0;
	endtask

	task automatic reread_sram();
		logic [31:0] addr, got;
		logic [1:0]  resp;
		for (int i = 0; i < SRAM_DEPTH; i++) begin
			addr = bus_pkg::SRAM_BASE + 4 * i;
			bus_read(addr, 0, got, resp);
			check_value("m_r_data_o", got, ref_read(addr));
			check_value("m_r_resp_o", resp, bus_pkg::RESP_OKAY);
		end
	endtask

	// uart strobes, sampled mid-cycle
	always @(negedge clk) begin
		if (uart_tx_valid_o === 1'b1) begin
			tx_count = tx_count + 1;
			tx_last  = uart_tx_data_o;
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: the bus did not finish within %0d cycles", CYCLE_LIMIT);
			fail_and_stop();
		end
	end

	initial begin : run_tests
		logic [31:0] addr, data, got, prev, rnd;
		logic [3:0]  strb;
		logic [1:0]  resp;
		int          idx, hold, count0;
		rst_i        = 1'b1;
		m_ar_addr_i  = '0;
		m_ar_valid_i = 1'b0;
		m_r_ready_i  = 1'b0;
		m_aw_addr_i  = '0;
		m_aw_valid_i = 1'b0;
		m_w_data_i   = '0;
		m_w_strb_i   = '0;
		m_w_valid_i  = 1'b0;
		m_b_ready_i  = 1'b0;
		repeat (5) @(negedge clk);
		rst_i = 1'b0;

		// preload so no byte stays unknown
		for (int i = 0; i < SRAM_DEPTH; i++) begin
			addr       = bus_pkg::SRAM_BASE + 4 * i;
			ref_mem[i] = fill_word(addr);
			bus_write(addr, ref_mem[i], 4'hf, 0, resp);
			check_value("m_b_resp_o", resp, bus_pkg::RESP_OKAY);
		end

		// random strobed writes, then read back what was touched
		for (int n = 0; n < N_RAND; n++) begin
			rnd  = xorshift();
			idx  = int'(rnd & (SRAM_DEPTH - 1));
			strb = rnd[19:16];
			data = xorshift();
			addr = bus_pkg::SRAM_BASE + 4 * idx;
			bus_write(addr, data, strb, 0, resp);
			check_value("m_b_resp_o", resp, bus_pkg::RESP_OKAY);
			ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
			touched[idx] = 1'b1;
		end
		for (int i = 0; i < SRAM_DEPTH; i++) begin
			if (touched[i]) begin
				addr = bus_pkg::SRAM_BASE + 4 * i;
				bus_read(addr, 0, got, resp);
				check_value("m_r_data_o", got, ref_read(addr));
				check_value("m_r_resp_o", resp, bus_pkg::RESP_OKAY);
			end
		end

		for (int n = 0; n < N_UART; n++) begin
			data   = xorshift();
			count0 = tx_count;
			bus_write(bus_pkg::UART_TX_ADDR, data, 4'hf, 0, resp);
			check_value("m_b_resp_o", resp, bus_pkg::RESP_OKAY);
			check_value("uart_tx_valid_o pulses", tx_count - count0, 1);
			check_value("uart_tx_data_o", tx_last, data[7:0]);
		end

		prev = '0;
		for (int n = 0; n < N_CLINT; n++) begin
			bus_read(bus_pkg::CLINT_MTIME_LO, 0, got, resp);
			check_value("m_r_resp_o", resp, bus_pkg::RESP_OKAY);
			check_value("mtime_lo rising", got > prev, 1'b1);
			prev = got;
		end
		bus_read(bus_pkg::CLINT_MTIME_HI, 0, got, resp);
		check_value("m_r_resp_o", resp, bus_pkg::RESP_OKAY);
		check_value("mtime_hi", got, 32'd0); // short run, no carry yet

		// unmapped or wrong direction
		count0 = tx_count;
		bus_read(bus_pkg::UART_TX_ADDR, 0, got, resp);
		check_value("m_r_resp_o", resp, bus_pkg::RESP_DECERR);
		check_value("m_r_data_o", got, 32'd0);
		bus_read(32'h4000_1000, 0, got, resp);
		check_value("m_r_resp_o", resp, bus_pkg::RESP_DECERR);
		check_value("m_r_data_o", got, 32'd0);
		bus_write(bus_pkg::CLINT_MTIME_LO, 32'hdead_beef, 4'hf, 0, resp);
		check_value("m_b_resp_o", resp, bus_pkg::RESP_DECERR);
		bus_write(bus_pkg::SRAM_BASE + 4 * SRAM_DEPTH, 32'h1234_5678, 4'hf, 0, resp);
		check_value("m_b_resp_o", resp, bus_pkg::RESP_DECERR);
		check_value("uart_tx_valid_o pulses", tx_count - count0, 0);
		reread_sram();

		// stalled responses
		for (int n = 0; n < N_BP; n++) begin
			rnd  = xorshift();
			idx  = int'(rnd & (SRAM_DEPTH - 1));
			hold = 1 + int'((rnd >> 8) & 32'd7);
			strb = rnd[19:16];
			data = xorshift();
			addr = bus_pkg::SRAM_BASE + 4 * idx;
			bus_write(addr, data, strb, hold, resp);
			check_value("m_b_resp_o", resp, bus_pkg::RESP_OKAY);
			ref_mem[idx] = merge_bytes(ref_mem[idx], data, strb);
			rnd  = xorshift();
			hold = 1 + int'(rnd & 32'd7);
			bus_read(addr, hold, got, resp);
			check_value("m_r_data_o", got, ref_read(addr));
			check_value("m_r_resp_o", resp, bus_pkg::RESP_OKAY);
		end
		bus_read(bus_pkg::CLINT_MTIME_LO, 5, got, resp);
		check_value("m_r_resp_o", resp, bus_pkg::RESP_OKAY);
		check_value("mtime_lo rising", got > prev, 1'b1);
		bus_read(32'h0000_0100, 3, got, resp);
		check_value("m_r_resp_o", resp, bus_pkg::RESP_DECERR);
		check_value("m_r_data_o", got, 32'd0);
		bus_write(32'h0000_0100, 32'hcafe_f00d, 4'hf, 4, resp);
		check_value("m_b_resp_o", resp, bus_pkg::RESP_DECERR);
		addr = bus_pkg::SRAM_BASE;
		bus_read(addr, 0, got, resp);
		check_value("m_r_data_o", got, ref_read(addr));
		check_value("m_r_resp_o", resp, bus_pkg::RESP_OKAY);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
